// ==== common/noc_consts.svh ====
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// ==========================================================================
// Router output port sizing
// ==========================================================================
`define NOC_NUM_PORTS 5   // Local, North, East, West, South
`define NOC_FLIT_W    32
`define NOC_LEN_W     12

// ==========================================================================
// Register map, byte offsets
// ==========================================================================
`define NOC_REG_MASK  'h00
`define NOC_REG_CNT0  'h04  // Counters at 0x04..0x14, stride 4
`define NOC_REG_CLR   'h18

`endif

// ==== common/noc_pkg.sv ====
`default_nettype none

`include "noc_consts.svh"

package noc_pkg;

  // Input channel index, also the outPort encoding
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } portIdxT;

  // Same code points as the router flit id
  typedef enum logic [2:0] {
    None = 3'd0,
    Head = 3'd1,
    Body = 3'd2,
    Tail = 3'd3
  } flitTypeT;

  // One-hot grant, all zeros is idle
  typedef logic [`NOC_NUM_PORTS-1:0] grantT;

endpackage

`default_nettype wire

// ==== arbiter/packetTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module packetTimer (
  input  logic                   clk,
  input  logic                   rst,
  input  noc_pkg::flitTypeT      flitType,
  input  logic [`NOC_LEN_W-1:0]  length,
  input  logic                   run,
  output logic                   done
);

  logic [`NOC_LEN_W-1:0] limit;
  logic [`NOC_LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitType == noc_pkg::Head)
        limit <= length;  // Packet length rides on the head flit
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign done = (count == limit);

endmodule

`default_nettype wire

// ==== arbiter/portArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module portArbiter (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [`NOC_NUM_PORTS-1:0]                  req,
  input  noc_pkg::flitTypeT [`NOC_NUM_PORTS-1:0]     flitType,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_LEN_W-1:0]  length,
  output noc_pkg::grantT                             grant
);

  noc_pkg::grantT              grantQ;
  noc_pkg::grantT              grantNext;
  logic [`NOC_NUM_PORTS-1:0]   run;
  logic [`NOC_NUM_PORTS-1:0]   done;
  logic [2:0]                  holder;

  // Channel offset steps away from base, wrapping past South
  function automatic logic [2:0] wrapIdx(input logic [2:0] base, input int offset);
    int sum;
    sum = int'(base) + offset;
    if (sum >= `NOC_NUM_PORTS)
      sum = sum - `NOC_NUM_PORTS;
    return sum[2:0];
  endfunction

  function automatic noc_pkg::grantT oneHot(input logic [2:0] idx);
    noc_pkg::grantT vec;
    vec = '0;
    vec[idx] = 1'b1;
    return vec;
  endfunction

  // ========================================================================
  // Per-channel packet timers
  // ========================================================================
  for (genvar i = 0; i < `NOC_NUM_PORTS; i++)
  begin : genTimer
    packetTimer timer_i (
      .clk      (clk),
      .rst      (rst),
      .flitType (flitType[i]),
      .length   (length[i]),
      .run      (run[i]),
      .done     (done[i])
    );
  end

  // ========================================================================
  // Grant selection
  // ========================================================================
  always_comb
  begin
    holder = 3'd0;
    for (int i = 0; i < `NOC_NUM_PORTS; i++)
      if (grantQ[i])
        holder = 3'(i);
  end

  always_comb
  begin
    grantNext = '0;
    run       = '0;
    if (grantQ == '0)
    begin
      // Idle, lowest index wins
      for (int i = `NOC_NUM_PORTS-1; i >= 0; i--)
        if (req[i])
          grantNext = oneHot(3'(i));
    end
    else if (req[holder] && !done[holder])
    begin
      grantNext    = grantQ;  // Keep the packet going
      run[holder]  = 1'b1;
    end
    else
    begin
      // Nearest requester after the holder, holder itself excluded
      for (int off = `NOC_NUM_PORTS-1; off >= 1; off--)
        if (req[wrapIdx(holder, off)])
          grantNext = oneHot(wrapIdx(holder, off));
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grantQ <= '0;
    else
      grantQ <= grantNext;
  end

  assign grant = grantQ;

endmodule

`default_nettype wire

// ==== design/outputMux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module outputMux (
  input  logic                                        clk,
  input  logic                                        rst,
  input  noc_pkg::grantT                              grant,
  input  logic [`NOC_NUM_PORTS-1:0]                   req,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_FLIT_W-1:0]  flit,
  output logic                                        outValid,
  output logic [`NOC_FLIT_W-1:0]                      outFlit,
  output noc_pkg::portIdxT                            outPort
);

  noc_pkg::portIdxT selIdx;
  logic             granted;

  // One-hot to index
  always_comb
  begin
    selIdx = noc_pkg::Local;
    for (int i = 0; i < `NOC_NUM_PORTS; i++)
      if (grant[i])
        selIdx = noc_pkg::portIdxT'(i);
  end

  assign granted = |grant;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= noc_pkg::Local;
    end
    else
    begin
      outValid <= granted & req[selIdx];
      if (granted)
        outPort <= selIdx;
    end
  end

  always_ff @(posedge clk)
  begin
    if (granted)
      outFlit <= flit[selIdx];  // Holds last flit while idle
  end

endmodule

`default_nettype wire

// ==== design/arbCfgRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module arbCfgRegs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [31:0]                axiAwaddr,
  input  logic                       axiAwvalid,
  output logic                       axiAwready,
  input  logic [31:0]                axiWdata,
  input  logic [3:0]                 axiWstrb,
  input  logic                       axiWvalid,
  output logic                       axiWready,
  output logic [1:0]                 axiBresp,
  output logic                       axiBvalid,
  input  logic                       axiBready,
  input  logic [31:0]                axiAraddr,
  input  logic                       axiArvalid,
  output logic                       axiArready,
  output logic [31:0]                axiRdata,
  output logic [1:0]                 axiRresp,
  output logic                       axiRvalid,
  input  logic                       axiRready,
  input  noc_pkg::grantT             grant,
  output logic [`NOC_NUM_PORTS-1:0]  enMask
);

  localparam int DataW = 32;

  logic                                  wrTake;
  logic                                  rdTake;
  logic                                  clrHit;
  logic [DataW-1:0]                      rdMux;
  noc_pkg::grantT                        grantD;
  noc_pkg::grantT                        grantRise;
  logic [`NOC_NUM_PORTS-1:0][DataW-1:0]  grantCnt;

  // ========================================================================
  // Write channel
  // ========================================================================
  assign wrTake     = axiAwvalid & axiWvalid & ~axiBvalid;
  assign axiAwready = wrTake;
  assign axiWready  = wrTake;
  assign axiBresp   = 2'b00;  // Always OKAY
  assign clrHit     = wrTake && (axiAwaddr == `NOC_REG_CLR);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      axiBvalid <= 1'b0;
      enMask    <= '1;
    end
    else
    begin
      if (wrTake)
        axiBvalid <= 1'b1;
      else if (axiBready)
        axiBvalid <= 1'b0;
      if (wrTake && axiAwaddr == `NOC_REG_MASK && axiWstrb[0])
        enMask <= axiWdata[`NOC_NUM_PORTS-1:0];
    end
  end

  // ========================================================================
  // Grant start counters
  // ========================================================================
  assign grantRise = grant & ~grantD;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantD   <= '0;
      grantCnt <= '0;
    end
    else
    begin
      grantD <= grant;
      for (int i = 0; i < `NOC_NUM_PORTS; i++)
        if (clrHit)
          grantCnt[i] <= '0;
        else if (grantRise[i])
          grantCnt[i] <= grantCnt[i] + 1'b1;
    end
  end

  // ========================================================================
  // Read channel
  // ========================================================================
  assign rdTake     = axiArvalid & ~axiRvalid;
  assign axiArready = rdTake;
  assign axiRresp   = 2'b00;

  always_comb
  begin
    rdMux = '0;  // Unmapped reads as zero
    if (axiAraddr == `NOC_REG_MASK)
      rdMux = {{(DataW-`NOC_NUM_PORTS){1'b0}}, enMask};
    for (int i = 0; i < `NOC_NUM_PORTS; i++)
      if (axiAraddr == `NOC_REG_CNT0 + 4 * i)
        rdMux = grantCnt[i];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      axiRvalid <= 1'b0;
    else if (rdTake)
      axiRvalid <= 1'b1;
    else if (axiRready)
      axiRvalid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rdTake)
      axiRdata <= rdMux;
  end

endmodule

`default_nettype wire

// ==== design/routerOutPort.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module routerOutPort (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [31:0]                                 axiAwaddr,
  input  logic                                        axiAwvalid,
  output logic                                        axiAwready,
  input  logic [31:0]                                 axiWdata,
  input  logic [3:0]                                  axiWstrb,
  input  logic                                        axiWvalid,
  output logic                                        axiWready,
  output logic [1:0]                                  axiBresp,
  output logic                                        axiBvalid,
  input  logic                                        axiBready,
  input  logic [31:0]                                 axiAraddr,
  input  logic                                        axiArvalid,
  output logic                                        axiArready,
  output logic [31:0]                                 axiRdata,
  output logic [1:0]                                  axiRresp,
  output logic                                        axiRvalid,
  input  logic                                        axiRready,
  input  logic [`NOC_NUM_PORTS-1:0]                   req,
  input  noc_pkg::flitTypeT [`NOC_NUM_PORTS-1:0]      flitType,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_LEN_W-1:0]   length,
  input  logic [`NOC_NUM_PORTS-1:0][`NOC_FLIT_W-1:0]  flit,
  output logic                                        outValid,
  output logic [`NOC_FLIT_W-1:0]                      outFlit,
  output noc_pkg::portIdxT                            outPort
);

  logic [`NOC_NUM_PORTS-1:0]  enMask;
  noc_pkg::grantT             grant;
  wire  [`NOC_NUM_PORTS-1:0]  reqGated;

  assign reqGated = req & enMask;  // Masked channels never compete

  arbCfgRegs arbCfgRegs_i (
    .clk        (clk),
    .rst        (rst),
    .axiAwaddr  (axiAwaddr),
    .axiAwvalid (axiAwvalid),
    .axiAwready (axiAwready),
    .axiWdata   (axiWdata),
    .axiWstrb   (axiWstrb),
    .axiWvalid  (axiWvalid),
    .axiWready  (axiWready),
    .axiBresp   (axiBresp),
    .axiBvalid  (axiBvalid),
    .axiBready  (axiBready),
    .axiAraddr  (axiAraddr),
    .axiArvalid (axiArvalid),
    .axiArready (axiArready),
    .axiRdata   (axiRdata),
    .axiRresp   (axiRresp),
    .axiRvalid  (axiRvalid),
    .axiRready  (axiRready),
    .grant      (grant),
    .enMask     (enMask)
  );

  portArbiter portArbiter_i (
    .clk      (clk),
    .rst      (rst),
    .req      (reqGated),
    .flitType (flitType),
    .length   (length),
    .grant    (grant)
  );

  outputMux outputMux_i (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (reqGated),
    .flit     (flit),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

// ==== verif/routerOutPort_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module routerOutPort_chk #(
  parameter bit CheckOut = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst,
  input  noc_pkg::grantT             grant,
  input  logic [`NOC_NUM_PORTS-1:0]  req,
  input  logic                       outValid,
  input  noc_pkg::portIdxT           outPort
);

  if (CheckOut)
  begin : genOut
    validFollowsGrant : assert property (@(posedge clk) disable iff (rst)
      outValid |-> ($past(grant) == (`NOC_NUM_PORTS'(1) << outPort)))
      else $error("outValid without a grant on outPort one cycle earlier");
  end
  else
  begin : genGrant
    // At most one channel owns the output
    grantOneHot : assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant))
      else $error("grant is not one-hot or zero");

    // Grant answers the requests of the cycle before
    grantNeedsReq : assert property (@(posedge clk) disable iff (rst)
      (grant & ~$past(req)) == '0)
      else $error("grant given to a channel that was not requesting");
  end

endmodule

bind outputMux routerOutPort_chk #(.CheckOut(1'b1)) outChk_i (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .req      (req),
  .outValid (outValid),
  .outPort  (outPort)
);

bind portArbiter routerOutPort_chk #(.CheckOut(1'b0)) arbChk_i (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .req      (req),
  .outValid (1'b0),
  .outPort  (noc_pkg::Local)
);

`default_nettype wire

// ==== verif/routerOutPort_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "noc_consts.svh"

module routerOutPort_tb;

  localparam int NumPorts = `NOC_NUM_PORTS;

  typedef struct packed {
    logic [NumPorts-1:0]              req;
    logic [3*NumPorts-1:0]            ft;
    logic [`NOC_LEN_W*NumPorts-1:0]   len;
    logic [NumPorts-1:0]              mask;
    logic [15:0]                      cycles;
  } stepT;

  logic                                   clk;
  logic                                   rst;
  logic [31:0]                            axiAwaddr;
  logic                                   axiAwvalid;
  logic                                   axiAwready;
  logic [31:0]                            axiWdata;
  logic [3:0]                             axiWstrb;
  logic                                   axiWvalid;
  logic                                   axiWready;
  logic [1:0]                             axiBresp;
  logic                                   axiBvalid;
  logic                                   axiBready;
  logic [31:0]                            axiAraddr;
  logic                                   axiArvalid;
  logic                                   axiArready;
  logic [31:0]                            axiRdata;
  logic [1:0]                             axiRresp;
  logic                                   axiRvalid;
  logic                                   axiRready;
  logic [NumPorts-1:0]                    req;
  noc_pkg::flitTypeT [NumPorts-1:0]       flitType;
  logic [NumPorts-1:0][`NOC_LEN_W-1:0]    length;
  logic [NumPorts-1:0][`NOC_FLIT_W-1:0]   flit;
  logic                                   outValid;
  logic [`NOC_FLIT_W-1:0]                 outFlit;
  noc_pkg::portIdxT                       outPort;

  // Reference model state
  int                     mGrant;  // -1 is idle
  logic [NumPorts-1:0]    mMask;
  logic [NumPorts-1:0]    mPrevGv;
  logic [`NOC_LEN_W-1:0]  mLimit [NumPorts];
  logic [`NOC_LEN_W-1:0]  mCount [NumPorts];
  logic [31:0]            mCnt [NumPorts];
  bit                     mBvalid;
  bit                     mRvalid;
  logic                   expValid;
  logic [2:0]             expPort;
  logic [31:0]            expFlit;
  logic [31:0]            rdExp;
  bit                     portKnown;
  bit                     wrTaken;
  bit                     rdTaken;

  int     errors;
  int     checks;
  int     testsPass;
  int     testsFail;
  int     watchCycles;
  stepT   steps [$];
  string  stepName [$];

  routerOutPort routerOutPort_i (.*);

  always #20 clk = ~clk;

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [3*NumPorts-1:0] typeOn(input int ch, input noc_pkg::flitTypeT t);
    return (3*NumPorts)'(t) << (3 * ch);
  endfunction

  function automatic logic [`NOC_LEN_W*NumPorts-1:0] lenOn(input int ch, input int l);
    return (`NOC_LEN_W*NumPorts)'(l) << (`NOC_LEN_W * ch);
  endfunction

  task automatic addStep(input string name, input logic [NumPorts-1:0] r,
                         input logic [3*NumPorts-1:0] ft,
                         input logic [`NOC_LEN_W*NumPorts-1:0] len,
                         input logic [NumPorts-1:0] mask, input int cycles);
    stepT s;
    s.req    = r;
    s.ft     = ft;
    s.len    = len;
    s.mask   = mask;
    s.cycles = 16'(cycles);
    steps.push_back(s);
    stepName.push_back(name);
  endtask

  task automatic checkVal(input string name, input logic [31:0] act, input logic [31:0] exp);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic finishTest(input string name, input int errStart);
    if (errors == errStart)
    begin
      testsPass++;
      $display("test %-16s ok", name);
    end
    else
    begin
      testsFail++;
      $display("test %-16s failed with %0d errors", name, errors - errStart);
    end
  endtask

  // One clock edge of the arbitration, timer and counter rules
  task automatic modelEdge();
    logic [NumPorts-1:0] g;
    logic [NumPorts-1:0] gv;
    int                  k;
    int                  j;
    int                  nextG;
    bit                  keep;
    g       = req & mMask;
    gv      = (mGrant < 0) ? '0 : NumPorts'(1 << mGrant);
    wrTaken = axiAwvalid && axiWvalid && !mBvalid;
    rdTaken = axiArvalid && !mRvalid;
    checkVal("axiAwready", 32'(axiAwready), 32'(wrTaken));
    checkVal("axiWready", 32'(axiWready), 32'(wrTaken));
    checkVal("axiArready", 32'(axiArready), 32'(rdTaken));
    mBvalid = wrTaken || (mBvalid && !axiBready);
    mRvalid = rdTaken || (mRvalid && !axiRready);
    if (rdTaken)
    begin
      rdExp = '0;
      if (axiAraddr == `NOC_REG_MASK)
        rdExp = 32'(mMask);
      for (int i = 0; i < NumPorts; i++)
        if (axiAraddr == 32'(`NOC_REG_CNT0 + 4 * i))
          rdExp = mCnt[i];
    end
    for (int i = 0; i < NumPorts; i++)
      if (wrTaken && axiAwaddr == `NOC_REG_CLR)
        mCnt[i] = '0;
      else if (gv[i] && !mPrevGv[i])
        mCnt[i] = mCnt[i] + 1;
    mPrevGv  = gv;
    expValid = (mGrant >= 0) && g[mGrant];
    if (mGrant >= 0)
    begin
      expPort   = 3'(mGrant);
      expFlit   = flit[mGrant];
      portKnown = 1'b1;
    end
    k     = mGrant;
    nextG = -1;
    keep  = 1'b0;
    if (k < 0)
    begin
      for (int i = 0; i < NumPorts; i++)
        if (g[i] && nextG < 0)
          nextG = i;
    end
    else if (g[k] && mCount[k] != mLimit[k])
    begin
      nextG = k;
      keep  = 1'b1;
    end
    else
      for (int off = 1; off < NumPorts; off++)
      begin
        j = (k + off) % NumPorts;
        if (g[j] && nextG < 0)
          nextG = j;
      end
    for (int i = 0; i < NumPorts; i++)
    begin
      mCount[i] = (keep && i == k) ? mCount[i] + 1'b1 : '0;
      if (flitType[i] == noc_pkg::Head)
        mLimit[i] = length[i];
    end
    if (wrTaken && axiAwaddr == `NOC_REG_MASK && axiWstrb[0])
      mMask = axiWdata[NumPorts-1:0];
    mGrant = nextG;
  endtask

  task automatic stepCycle();
    @(negedge clk);
    modelEdge();
    @(posedge clk);
    #2;
    checkVal("outValid", 32'(outValid), 32'(expValid));
    if (portKnown)
    begin
      checkVal("outPort", 32'(outPort), 32'(expPort));
      checkVal("outFlit", outFlit, expFlit);
    end
  endtask

  // ==========================================================================
  // AXI4-Lite accesses with held-off responses
  // ==========================================================================
  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data);
    axiAwaddr  = addr;
    axiWdata   = data;
    axiWstrb   = 4'hF;
    axiAwvalid = 1'b1;
    axiWvalid  = 1'b1;
    axiBready  = 1'b0;
    do
      stepCycle();
    while (!wrTaken);
    axiAwvalid = 1'b0;
    axiWvalid  = 1'b0;
    repeat (3)
    begin
      stepCycle();
      checkVal("axiBvalid", 32'(axiBvalid), 32'h1);  // Must wait for bready
    end
    checkVal("axiBresp", 32'(axiBresp), 32'h0);
    axiBready = 1'b1;
    stepCycle();
    checkVal("axiBvalid", 32'(axiBvalid), 32'h0);
    axiBready = 1'b0;
  endtask

  task automatic axiRead(input logic [31:0] addr, output logic [31:0] data);
    axiAraddr  = addr;
    axiArvalid = 1'b1;
    axiRready  = 1'b0;
    do
      stepCycle();
    while (!rdTaken);
    axiArvalid = 1'b0;
    repeat (3)
    begin
      stepCycle();
      checkVal("axiRvalid", 32'(axiRvalid), 32'h1);
    end
    checkVal("axiRdata", axiRdata, rdExp);
    checkVal("axiRresp", 32'(axiRresp), 32'h0);
    data      = axiRdata;
    axiRready = 1'b1;
    stepCycle();
    checkVal("axiRvalid", 32'(axiRvalid), 32'h0);
    axiRready = 1'b0;
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    logic [31:0] rd;
    int          errStart;
    void'($urandom(4));
    clk        = 1'b0;
    rst        = 1'b1;
    axiAwaddr  = '0;
    axiAwvalid = 1'b0;
    axiWdata   = '0;
    axiWstrb   = '0;
    axiWvalid  = 1'b0;
    axiBready  = 1'b0;
    axiAraddr  = '0;
    axiArvalid = 1'b0;
    axiRready  = 1'b0;
    req        = '0;
    length     = '0;
    flit       = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      flitType[i] = noc_pkg::None;
      mLimit[i]   = '0;
      mCount[i]   = '0;
      mCnt[i]     = '0;
    end
    mGrant    = -1;
    mMask     = '1;
    mPrevGv   = '0;
    mBvalid   = 1'b0;
    mRvalid   = 1'b0;
    portKnown = 1'b0;

    addStep("idle priority", 5'h1F, '0, '0, 5'h1F, 6);
    addStep("release Local", 5'h1E, '0, '0, 5'h1F, 3);
    addStep("release North", 5'h1C, '0, '0, 5'h1F, 3);
    addStep("release East", 5'h18, '0, '0, 5'h1F, 3);
    addStep("release West", 5'h10, '0, '0, 5'h1F, 3);
    addStep("drain", 5'h00, '0, '0, 5'h1F, 3);
    addStep("head len 0", 5'h0A, typeOn(1, noc_pkg::Head), lenOn(1, 0), 5'h1F, 1);
    addStep("hold len 0", 5'h0A, typeOn(1, noc_pkg::Body), '0, 5'h1F, 6);
    addStep("drain", 5'h00, '0, '0, 5'h1F, 3);
    addStep("head len 3", 5'h11, typeOn(0, noc_pkg::Head), lenOn(0, 3), 5'h1F, 1);
    addStep("hold len 3", 5'h11, typeOn(0, noc_pkg::Body), '0, 5'h1F, 10);
    addStep("drain", 5'h00, '0, '0, 5'h1F, 3);
    addStep("head len 7", 5'h0C, typeOn(2, noc_pkg::Head), lenOn(2, 7), 5'h1F, 1);
    addStep("hold len 7", 5'h0C, typeOn(2, noc_pkg::Body), '0, 5'h1F, 14);
    addStep("drain", 5'h00, '0, '0, 5'h1F, 3);
    addStep("sole head", 5'h04, typeOn(2, noc_pkg::Head), lenOn(2, 2), 5'h1F, 1);
    addStep("sole timeout", 5'h04, typeOn(2, noc_pkg::Body), '0, 5'h1F, 10);
    addStep("drain", 5'h00, '0, '0, 5'h1F, 3);
    addStep("mask 0x15", 5'h1F, '0, '0, 5'h15, 12);
    addStep("masked heads", 5'h1F, typeOn(1, noc_pkg::Head) | typeOn(4, noc_pkg::Head),
            lenOn(1, 5) | lenOn(4, 2), 5'h15, 10);
    addStep("drain", 5'h00, '0, '0, 5'h15, 4);

    watchCycles = 400;  // Reset, register accesses and slack
    foreach (steps[s])
      watchCycles += int'(steps[s].cycles);

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    errStart = errors;
    checkVal("outValid", 32'(outValid), 32'h0);
    checkVal("axiBvalid", 32'(axiBvalid), 32'h0);
    checkVal("axiRvalid", 32'(axiRvalid), 32'h0);
    axiRead(`NOC_REG_MASK, rd);
    checkVal("enMask", rd, 32'h1F);
    finishTest("reset state", errStart);

    foreach (steps[s])
    begin
      errStart = errors;
      if (steps[s].mask != mMask)
        axiWrite(`NOC_REG_MASK, 32'(steps[s].mask));
      req    = steps[s].req;
      length = steps[s].len;
      for (int i = 0; i < NumPorts; i++)
        flitType[i] = noc_pkg::flitTypeT'(steps[s].ft[3*i +: 3]);
      for (int c = 0; c < int'(steps[s].cycles); c++)
      begin
        for (int i = 0; i < NumPorts; i++)
          flit[i] = $urandom;
        stepCycle();
      end
      finishTest(stepName[s], errStart);
    end

    errStart = errors;
    for (int i = 0; i < NumPorts; i++)
      axiRead(32'(`NOC_REG_CNT0 + 4 * i), rd);
    finishTest("counter reads", errStart);

    errStart = errors;
    axiWrite(`NOC_REG_CLR, 32'h0);
    for (int i = 0; i < NumPorts; i++)
    begin
      axiRead(32'(`NOC_REG_CNT0 + 4 * i), rd);
      checkVal("grantCnt", rd, 32'h0);
    end
    finishTest("counter clear", errStart);

    $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
             testsPass, testsFail, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (watchCycles > 0);
    repeat (watchCycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/noc_pkg.sv
arbiter/packetTimer.sv
arbiter/portArbiter.sv
design/outputMux.sv
design/arbCfgRegs.sv
design/routerOutPort.sv
verif/routerOutPort_chk.sv
verif/routerOutPort_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the router output port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module routerOutPort_tb -f all.f -o simv

out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"
